//--- files.f
+incdir+common
common/hl2link_pkg.sv
link/link_tx.sv
link/link_rx.sv
link/link_tx_arbiter.sv
design/link_cmd_ctrl.sv
design/hl2link_top.sv
dv/link_peer_model.sv
dv/hl2link_assert.sv
dv/hl2link_tb.sv

//--- dv/hl2link_tb.sv
`default_nettype none

`include "hl2link_cfg.svh"

module hl2link_tb;

  import hl2link_pkg::*;

  logic        clk = 1'b0;
  logic        reset;
  logic [1:0]  linkrx;
  logic [1:0]  linktx;
  logic        ls_valid;
  sample_t     ls_data;
  logic        ds_cmd_rqst;
  host_cmd_t   ds_cmd;
  logic        cmd_rqst;
  logic        running;
  logic        master_sel;
  logic        rst_all;
  logic        rst_nco;
  sample_t     lm_data;
  logic        lm_valid;
  logic        ls_done;
  local_cmd_t  cmd;
  logic        cmd_cnt;
  logic        ka_en;
  logic        send_valid;
  link_frame_t send_frame;
  logic        send_ack;
  logic        dec_valid;
  link_frame_t dec_frame;

  int errors = 0;
  int checks = 0;
  int ls_done_cnt = 0;
  int rst_all_cnt = 0;
  int rst_nco_cnt = 0;
  int rst_link_cnt = 0;
  int run_hold = 0;
  local_cmd_t  cmd_q[$];
  link_frame_t peer_q[$];
  sample_t     lm_q[$];

  hl2link_top i_dut (
    .clk, .reset, .linkrx, .ls_valid, .ls_data, .ds_cmd_rqst, .ds_cmd, .cmd_rqst,
    .linktx, .running, .master_sel, .rst_all, .rst_nco, .lm_data, .lm_valid,
    .ls_done, .cmd, .cmd_cnt
  );

  link_peer_model i_peer (
    .clk, .reset, .ka_en, .send_valid, .send_frame, .linktx,
    .linkrx, .send_ack, .dec_valid, .dec_frame
  );

  always #20 clk = ~clk;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  function automatic bit is_ready(input int which);
    case (which)
      0: return cmd_q.size() > 0;
      1: return peer_q.size() > 0;
      2: return lm_q.size() > 0;
      3: return running;
      default: return !running;
    endcase
  endfunction

  task automatic wait_until(input int which, input int limit, input string what);
    int n;
    n = 0;
    while (!is_ready(which) && n < limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!is_ready(which)) report_failure({"timeout waiting for ", what});
  endtask

  task automatic send_peer_frame(input link_frame_t f);
    int n;
    n = 0;
    send_frame = f;
    send_valid = 1'b1;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!send_ack && n < 100);
    #1;
    send_valid = 1'b0;
    if (!send_ack) report_failure("peer never accepted a frame");
  endtask

  task automatic host_command(input host_cmd_t c);
    ds_cmd      = c;
    ds_cmd_rqst = 1'b1;
    @(posedge clk);
    #2;
    ds_cmd_rqst = 1'b0;
  endtask

  // Local consumer answers each cmd_cnt toggle
  initial begin
    logic last_cnt;
    last_cnt = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && cmd_cnt !== last_cnt) begin
        last_cnt = cmd_cnt;
        cmd_q.push_back(cmd);
        #1;
        cmd_rqst = 1'b1;
        @(posedge clk);
        #2;
        cmd_rqst = 1'b0;
      end
    end
  end

  // Output monitors
  always @(posedge clk) begin
    #1;
    if (dec_valid && dec_frame.ftype != FT_KEEPALIVE) peer_q.push_back(dec_frame);
    if (lm_valid) lm_q.push_back(lm_data);
    if (ls_done) ls_done_cnt++;
    if (rst_all) rst_all_cnt++;
    if (rst_nco) rst_nco_cnt++;
    if (i_dut.rst_link) rst_link_cnt++;
    if (i_dut.rx_done) run_hold = 0;
    else if (running) run_hold++;
  end

  initial begin
    repeat (400000) @(posedge clk);
    $display("ERROR: simulation ran past its cycle limit");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int          err0;
    int          n;
    bit          expect_tgl;
    bit          link_up;
    local_cmd_t  lc;
    link_frame_t f;
    host_cmd_t   hc;
    sample_t     s;
    void'($urandom(32'h35c3));
    link_up = 1'b0;
    reset = 1'b1;
    ls_valid = 1'b0;
    ls_data = '0;
    ds_cmd_rqst = 1'b0;
    ds_cmd = '0;
    cmd_rqst = 1'b0;
    ka_en = 1'b0;
    send_valid = 1'b0;
    send_frame = '0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    compare("linktx", linktx, 0);
    compare("running", running, 0);
    compare("master_sel", master_sel, 0);
    compare("cmd_cnt", cmd_cnt, 0);

    // Test 1 link-up in slave mode
    err0 = errors;
    ka_en = 1'b1;
    wait_until(3, 200, "running");
    link_up = 1'b1;
    wait_until(0, 50, "clock-enable command");
    if (cmd_q.size() > 0) begin
      lc = cmd_q.pop_front();
      compare("cmd.addr", lc.addr, `HL2_CTRL_ADDR);
      compare("cmd.data", lc.data, `HL2_CLK1ON_DATA);
    end
    $display("test 1 slave link-up: %0d errors", errors - err0);

    // Test 2 slave receive
    err0 = errors;
    idle_cycles(10);
    for (int i = 0; i < 20; i++) begin
      f.payload = link_word_t'({$urandom(), $urandom()});
      if ($urandom_range(1)) begin
        f.ftype = FT_CMD;
        if (f.payload[37:32] == `HL2_CTRL_ADDR) f.payload[37:32] = 6'h00;
        send_peer_frame(f);
        wait_until(0, 60, "received command");
        if (cmd_q.size() > 0) begin
          lc = cmd_q.pop_front();
          compare("cmd.addr", lc.addr, f.payload[37:32]);
          compare("cmd.data", lc.data, f.payload[31:0]);
        end
      end else begin
        f.ftype = FT_SAMPLE;
        send_peer_frame(f);
        wait_until(2, 60, "lm_valid");
        if (lm_q.size() > 0) compare("lm_data", lm_q.pop_front(), f.payload[37:14]);
      end
    end
    idle_cycles(30);
    compare("extra cmd_cnt toggles", cmd_q.size(), 0);
    compare("extra lm_valid", lm_q.size(), 0);
    $display("test 2 slave receive: %0d errors", errors - err0);

    // Test 3 slave sample transmit
    err0 = errors;
    ls_done_cnt = 0;
    for (int i = 0; i < 8; i++) begin
      s = sample_t'($urandom());
      ls_data = s;
      ls_valid = 1'b1;
      n = 0;
      do begin
        @(posedge clk);
        #1;
        n++;
      end while (!ls_done && n < 100);
      if (!ls_done) report_failure("ls_done never pulsed");
      #1;
      ls_valid = 1'b0;
      wait_until(1, 20, "sample frame at peer");
      if (peer_q.size() > 0) begin
        f = peer_q.pop_front();
        compare("frame.ftype", f.ftype, FT_SAMPLE);
        compare("frame.payload", f.payload, {s, 14'h0});
      end
      idle_cycles(5);
      compare("ls_done count", ls_done_cnt, i + 1);
    end
    $display("test 3 slave sample transmit: %0d errors", errors - err0);

    // Test 4 master mode and host commands
    err0 = errors;
    hc = '0;
    hc.addr = `HL2_CTRL_ADDR;
    hc.data[`HL2_MASTER_EN_BIT] = 1'b1;
    hc.data[`HL2_MASTER_VAL_BIT] = 1'b1;
    expect_tgl = !link_up;
    host_command(hc);
    idle_cycles(60);
    compare("master_sel", master_sel, 1);
    compare("ctrl write toggles", cmd_q.size(), expect_tgl);
    cmd_q.delete();
    for (int i = 0; i < 20; i++) begin
      hc.addr = cmd_addr_t'($urandom());
      if (hc.addr == `HL2_CTRL_ADDR) hc.addr = 6'h01;
      hc.data = $urandom();
      hc.resprqst = $urandom_range(1);
      hc.is_alt = $urandom_range(1);
      hc.mask = $urandom_range(3);
      expect_tgl = hc.mask[0] || !link_up;
      host_command(hc);
      if (hc.mask[1]) begin
        wait_until(1, 80, "command frame at peer");
        if (peer_q.size() > 0) begin
          f = peer_q.pop_front();
          compare("frame.ftype", f.ftype, FT_CMD);
          compare("frame.payload", f.payload, {hc.addr, hc.data});
        end
      end
      if (expect_tgl) begin
        wait_until(0, 80, "local command");
        if (cmd_q.size() > 0) begin
          lc = cmd_q.pop_front();
          compare("cmd.addr", lc.addr, hc.addr);
          compare("cmd.data", lc.data, hc.data);
          compare("cmd.resprqst", lc.resprqst, hc.resprqst);
          compare("cmd.is_alt", lc.is_alt, hc.is_alt);
        end
      end
      idle_cycles(60);
      compare("extra cmd_cnt toggles", cmd_q.size(), 0);
      compare("extra peer frames", peer_q.size(), 0);
    end
    $display("test 4 master commands: %0d errors", errors - err0);

    // Test 5 reset decode from local control writes
    err0 = errors;
    rst_all_cnt = 0;
    rst_nco_cnt = 0;
    n = 0;
    for (int i = 0; i < 6; i++) begin
      hc = '0;
      hc.addr = `HL2_CTRL_ADDR;
      hc.data = $urandom();
      hc.data[`HL2_MASTER_EN_BIT] = 1'b0;
      hc.data[`HL2_RESET_EN_BIT] = 1'b1;
      hc.mask = 2'b01;
      if (hc.data[`HL2_RESET_SEL_BIT]) n++;
      host_command(hc);
      wait_until(0, 60, "local control write");
      cmd_q.delete();
      idle_cycles(60);
      compare("rst_nco count", rst_nco_cnt, n);
      compare("rst_all count", rst_all_cnt, i + 1 - n);
    end
    $display("test 5 reset decode: %0d errors", errors - err0);

    // Test 6 link loss and back to slave mode
    err0 = errors;
    ka_en = 1'b0;
    wait_until(4, `HL2_RUNNING_TIMEOUT + 150, "running to fall");
    compare("running hold cycles", run_hold, `HL2_RUNNING_TIMEOUT);
    link_up = 1'b0;
    rst_link_cnt = 0;
    hc = '0;
    hc.addr = `HL2_CTRL_ADDR;
    hc.data[`HL2_MASTER_EN_BIT] = 1'b1;
    hc.mask = 2'b01;
    host_command(hc);
    wait_until(0, 60, "master clear command");
    cmd_q.delete();
    idle_cycles(10);
    compare("master_sel", master_sel, 0);
    compare("link reset count", rst_link_cnt, 1);
    ka_en = 1'b1;
    wait_until(3, 200, "running after link reset");
    link_up = 1'b1;
    wait_until(0, 50, "clock-enable command");
    if (cmd_q.size() > 0) begin
      lc = cmd_q.pop_front();
      compare("cmd.addr", lc.addr, `HL2_CTRL_ADDR);
      compare("cmd.data", lc.data, `HL2_CLK1ON_DATA);
    end
    $display("test 6 link loss and slave return: %0d errors", errors - err0);

    errors += i_dut.i_assert.fail_cnt;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/hl2link_assert.sv
`default_nettype none

module hl2link_assert (
  input wire       clk,
  input wire       reset,
  input wire       rst_all,
  input wire       rst_nco,
  input wire       tx_ready,
  input wire       lm_valid,
  input wire       rx_done,
  input wire [1:0] linktx
);

  int fail_cnt = 0;

  a_rst_excl: assert property (@(posedge clk) disable iff (reset)
    !(rst_all && rst_nco))
  else begin
    fail_cnt++;
    $error("rst_all and rst_nco high together");
  end

  // Idle transmitter keeps the lane quiet
  a_idle_lane: assert property (@(posedge clk) disable iff (reset)
    tx_ready |-> linktx == 2'b00)
  else begin
    fail_cnt++;
    $error("linktx not 00 while transmitter idle");
  end

  a_lm_valid: assert property (@(posedge clk) disable iff (reset)
    lm_valid |-> $past(rx_done))
  else begin
    fail_cnt++;
    $error("lm_valid without rx_done in previous cycle");
  end

endmodule

bind hl2link_top hl2link_assert i_assert (
  .clk      (clk),
  .reset    (reset),
  .rst_all  (rst_all),
  .rst_nco  (rst_nco),
  .tx_ready (tx_ready),
  .lm_valid (lm_valid),
  .rx_done  (rx_done),
  .linktx   (linktx)
);

`default_nettype wire

//--- dv/link_peer_model.sv
`default_nettype none

`include "hl2link_cfg.svh"

module link_peer_model (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           ka_en,
  input  wire                           send_valid,
  input  wire hl2link_pkg::link_frame_t send_frame,
  input  wire  [1:0]                    linktx,
  output logic [1:0]                    linkrx,
  output logic                          send_ack,
  output logic                          dec_valid,
  output hl2link_pkg::link_frame_t      dec_frame
);

  import hl2link_pkg::*;

  localparam int unsigned KA_GAP = 50;
  localparam int unsigned FRAME_SYMS = 20;

  int unsigned tx_left;
  int unsigned idle_cnt;
  logic [39:0] tx_sh;
  int unsigned rx_left;
  logic [39:0] rx_sh;

  // Encoder, a requested frame wins over the keepalive
  always @(posedge clk) begin
    if (reset) begin
      linkrx   <= 2'b00;
      tx_left  <= 0;
      idle_cnt <= 0;
      send_ack <= 1'b0;
    end else begin
      send_ack <= 1'b0;
      if (tx_left != 0) begin
        linkrx  <= tx_sh[39:38];
        tx_sh   <= {tx_sh[37:0], 2'b00};
        tx_left <= tx_left - 1;
      end else if (send_valid) begin
        linkrx   <= `HL2_START_SYM;
        tx_sh    <= send_frame;
        tx_left  <= FRAME_SYMS;
        idle_cnt <= 0;
        send_ack <= 1'b1;
      end else if (ka_en && idle_cnt >= KA_GAP - 1) begin
        linkrx   <= `HL2_START_SYM;
        tx_sh    <= '0;
        tx_left  <= FRAME_SYMS;
        idle_cnt <= 0;
      end else begin
        linkrx   <= 2'b00;
        idle_cnt <= idle_cnt + 1;
      end
    end
  end

  // Decoder for the DUT's transmit lane
  always @(posedge clk) begin
    if (reset) begin
      rx_left   <= 0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= 1'b0;
      if (rx_left != 0) begin
        rx_sh   <= {rx_sh[37:0], linktx};
        rx_left <= rx_left - 1;
        if (rx_left == 1) begin
          dec_valid <= 1'b1;
          dec_frame <= {rx_sh[37:0], linktx};
        end
      end else if (linktx == `HL2_START_SYM) begin
        rx_left <= FRAME_SYMS;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/hl2link_top.sv
`default_nettype none

module hl2link_top (
  input  wire                         clk,
  input  wire                         reset,
  input  wire  [1:0]                  linkrx,
  input  wire                         ls_valid,
  input  wire hl2link_pkg::sample_t   ls_data,
  input  wire                         ds_cmd_rqst,
  input  wire hl2link_pkg::host_cmd_t ds_cmd,
  input  wire                         cmd_rqst,
  output logic [1:0]                  linktx,
  output logic                        running,
  output logic                        master_sel,
  output logic                        rst_all,
  output logic                        rst_nco,
  output hl2link_pkg::sample_t        lm_data,
  output logic                        lm_valid,
  output logic                        ls_done,
  output hl2link_pkg::local_cmd_t     cmd,
  output logic                        cmd_cnt
);

  import hl2link_pkg::*;

  logic        rst_link;
  logic        link_reset;
  logic        cmd_frame_valid;
  link_frame_t cmd_frame;
  logic        cmd_frame_done;
  logic        tx_valid;
  link_frame_t tx_frame;
  logic        tx_ready;
  logic        tx_done;
  logic        rx_done;
  link_frame_t rx_frame;
  logic        clk1on_rqst;
  logic        clk1on_ack;

  assign link_reset = reset | rst_link;

  link_cmd_ctrl i_cmd_ctrl (
    .clk,
    .reset,
    .ds_cmd_rqst,
    .ds_cmd,
    .cmd_rqst,
    .rx_done,
    .rx_frame,
    .running,
    .clk1on_rqst,
    .cmd_frame_done,
    .cmd,
    .cmd_cnt,
    .master_sel,
    .rst_all,
    .rst_nco,
    .rst_link,
    .cmd_frame_valid,
    .cmd_frame,
    .clk1on_ack
  );

  link_tx_arbiter i_arbiter (
    .clk,
    .reset (link_reset),
    .master_sel,
    .cmd_frame_valid,
    .cmd_frame,
    .ls_valid,
    .ls_data,
    .tx_ready,
    .tx_done,
    .cmd_frame_done,
    .ls_done,
    .tx_valid,
    .tx_frame
  );

  link_tx i_link_tx (
    .clk,
    .reset (link_reset),
    .tx_valid,
    .tx_frame,
    .tx_ready,
    .tx_done,
    .linktx
  );

  link_rx i_link_rx (
    .clk,
    .reset (link_reset),
    .linkrx,
    .master_sel,
    .clk1on_ack,
    .rx_done,
    .rx_frame,
    .running,
    .clk1on_rqst
  );

  // Sample word sits in the top 24 payload bits
  always_ff @(posedge clk) begin
    if (link_reset) begin
      lm_valid <= 1'b0;
    end else begin
      lm_valid <= rx_done & (rx_frame.ftype == FT_SAMPLE);
    end
  end

  always_ff @(posedge clk) begin
    if (rx_done) begin
      lm_data <= rx_frame.payload[37:14];
    end
  end

endmodule

`default_nettype wire

//--- design/link_cmd_ctrl.sv
`default_nettype none

`include "hl2link_cfg.svh"

module link_cmd_ctrl (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           ds_cmd_rqst,
  input  wire hl2link_pkg::host_cmd_t   ds_cmd,
  input  wire                           cmd_rqst,
  input  wire                           rx_done,
  input  wire hl2link_pkg::link_frame_t rx_frame,
  input  wire                           running,
  input  wire                           clk1on_rqst,
  input  wire                           cmd_frame_done,
  output hl2link_pkg::local_cmd_t       cmd,
  output logic                          cmd_cnt,
  output logic                          master_sel,
  output logic                          rst_all,
  output logic                          rst_nco,
  output logic                          rst_link,
  output logic                          cmd_frame_valid,
  output hl2link_pkg::link_frame_t      cmd_frame,
  output logic                          clk1on_ack
);

  import hl2link_pkg::*;

  cmd_state_t state;
  logic       deliver_local;
  logic       rx_cmd;
  logic       clk_take;
  logic       host_take;
  logic       host_ctrl_wr;
  logic       local_ctrl_wr;

  // Received commands first, then clock-enable, then host
  assign rx_cmd    = rx_done & (rx_frame.ftype == FT_CMD) & ~master_sel;
  assign clk_take  = clk1on_rqst & ~master_sel;
  assign host_take = ds_cmd_rqst & ~rx_cmd & ~clk_take;

  assign host_ctrl_wr  = ds_cmd_rqst & (ds_cmd.addr == `HL2_CTRL_ADDR) &
                         ds_cmd.data[`HL2_MASTER_EN_BIT];
  assign local_ctrl_wr = cmd_rqst & (cmd.addr == `HL2_CTRL_ADDR);

  assign clk1on_ack = (state == CMD_CLK1);

  // Master select only from the host side
  always_ff @(posedge clk) begin
    if (reset) begin
      master_sel <= 1'b0;
    end else if (host_ctrl_wr) begin
      master_sel <= ds_cmd.data[`HL2_MASTER_VAL_BIT];
    end
  end

  // Reset pulses follow the local consumer's acknowledge
  always_ff @(posedge clk) begin
    if (reset) begin
      rst_all  <= 1'b0;
      rst_nco  <= 1'b0;
      rst_link <= 1'b0;
    end else begin
      rst_all  <= local_ctrl_wr & cmd.data[`HL2_RESET_EN_BIT] & ~cmd.data[`HL2_RESET_SEL_BIT];
      rst_nco  <= local_ctrl_wr & cmd.data[`HL2_RESET_EN_BIT] & cmd.data[`HL2_RESET_SEL_BIT];
      // Leaving master mode restarts the link
      rst_link <= local_ctrl_wr & cmd.data[`HL2_MASTER_EN_BIT] &
                  ~cmd.data[`HL2_MASTER_VAL_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= CMD_IDLE;
      cmd_cnt         <= 1'b0;
      cmd_frame_valid <= 1'b0;
    end else begin
      if (cmd_frame_done || !master_sel) begin
        cmd_frame_valid <= 1'b0;
      end
      case (state)
        CMD_IDLE: begin
          if (rx_cmd) begin
            state <= CMD_SLV0;
          end else if (clk_take) begin
            state <= CMD_CLK0;
          end else if (host_take) begin
            if (master_sel && ds_cmd.mask[1]) begin
              cmd_frame_valid <= 1'b1;
            end
            // Wait for the frame to go out only while the link is up
            if (running && master_sel && ds_cmd.mask[1]) begin
              state <= CMD_MST0;
            end else begin
              state <= CMD_MST1;
            end
          end
        end
        CMD_MST0: begin
          if (cmd_frame_done || !master_sel) begin
            state <= CMD_MST1;
          end
        end
        CMD_MST1: begin
          if (deliver_local || !running) begin
            cmd_cnt <= ~cmd_cnt;
          end
          state <= CMD_IDLE;
        end
        CMD_SLV0: begin
          cmd_cnt <= ~cmd_cnt;
          state   <= CMD_IDLE;
        end
        CMD_CLK0: begin
          cmd_cnt <= ~cmd_cnt;
          state   <= CMD_CLK1;
        end
        CMD_CLK1: begin
          if (!clk1on_rqst) begin
            state <= CMD_IDLE;
          end
        end
        default: state <= CMD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == CMD_IDLE && host_take) begin
      cmd.addr      <= ds_cmd.addr;
      cmd.data      <= ds_cmd.data;
      cmd.resprqst  <= ds_cmd.resprqst;
      cmd.is_alt    <= ds_cmd.is_alt;
      cmd_frame     <= '{ftype: FT_CMD, payload: {ds_cmd.addr, ds_cmd.data}};
      deliver_local <= ds_cmd.mask[0];
    end else if (state == CMD_SLV0) begin
      cmd.addr     <= rx_frame.payload[37:32];
      cmd.data     <= rx_frame.payload[31:0];
      cmd.resprqst <= 1'b0;
      cmd.is_alt   <= 1'b0;
    end else if (state == CMD_CLK0) begin
      cmd.addr     <= `HL2_CTRL_ADDR;
      cmd.data     <= `HL2_CLK1ON_DATA;
      cmd.resprqst <= 1'b0;
      cmd.is_alt   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- link/link_tx_arbiter.sv
`default_nettype none

`include "hl2link_cfg.svh"

module link_tx_arbiter (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           master_sel,
  input  wire                           cmd_frame_valid,
  input  wire hl2link_pkg::link_frame_t cmd_frame,
  input  wire                           ls_valid,
  input  wire hl2link_pkg::sample_t     ls_data,
  input  wire                           tx_ready,
  input  wire                           tx_done,
  output logic                          cmd_frame_done,
  output logic                          ls_done,
  output logic                          tx_valid,
  output hl2link_pkg::link_frame_t      tx_frame
);

  import hl2link_pkg::*;

  localparam int unsigned KA_W  = $clog2(`HL2_KEEPALIVE_CYCLES + 1);
  localparam int unsigned PAD_W = $bits(link_word_t) - $bits(sample_t);

  logic [KA_W-1:0] ka_cnt;
  logic            ka_rqst;
  logic            cmd_req;
  logic            smp_req;
  logic            accept;
  frame_type_t     grant;

  assign cmd_req  = master_sel & cmd_frame_valid;
  assign smp_req  = ~master_sel & ls_valid;
  assign ka_rqst  = (ka_cnt == KA_W'(`HL2_KEEPALIVE_CYCLES));
  assign tx_valid = cmd_req | smp_req | ka_rqst;
  assign accept   = tx_valid & tx_ready;

  always_comb begin
    if (cmd_req) begin
      tx_frame = cmd_frame;
    end else if (smp_req) begin
      tx_frame = '{ftype: FT_SAMPLE, payload: {ls_data, {PAD_W{1'b0}}}};
    end else begin
      tx_frame = '{ftype: FT_KEEPALIVE, payload: '0};
    end
  end

  // Idle cycles of the transmitter since the last accept
  always_ff @(posedge clk) begin
    if (reset || accept) begin
      ka_cnt <= '0;
    end else if (tx_ready && !ka_rqst) begin
      ka_cnt <= ka_cnt + 1'b1;
    end
  end

  // Frame type of the granted frame tells whose done it is
  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= FT_KEEPALIVE;
    end else if (accept) begin
      grant <= tx_frame.ftype;
    end
  end

  assign cmd_frame_done = tx_done & (grant == FT_CMD);
  assign ls_done        = tx_done & (grant == FT_SAMPLE);

endmodule

`default_nettype wire

//--- link/link_rx.sv
`default_nettype none

`include "hl2link_cfg.svh"

module link_rx (
  input  wire                            clk,
  input  wire                            reset,
  input  wire  [1:0]                     linkrx,
  input  wire                            master_sel,
  input  wire                            clk1on_ack,
  output logic                           rx_done,
  output hl2link_pkg::link_frame_t       rx_frame,
  output logic                           running,
  output logic                           clk1on_rqst
);

  import hl2link_pkg::*;

  localparam logic [4:0] LAST_SYM = 5'd18;
  localparam int unsigned WD_W = $clog2(`HL2_RUNNING_TIMEOUT + 1);

  rx_state_t        state;
  logic [4:0]       sym_cnt;
  logic [39:0]      shreg;
  logic [WD_W-1:0]  wd_cnt;

  assign rx_frame = shreg;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= RX_HUNT;
      sym_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        RX_HUNT: begin
          if (linkrx == `HL2_START_SYM) begin
            state <= RX_TYPE;
          end
        end
        RX_TYPE: begin
          sym_cnt <= '0;
          state   <= RX_DATA;
        end
        RX_DATA: begin
          sym_cnt <= sym_cnt + 5'd1;
          if (sym_cnt == LAST_SYM) begin
            rx_done <= 1'b1;
            state   <= RX_HUNT;
          end
        end
        default: state <= RX_HUNT;
      endcase
    end
  end

  // Type symbol first, then the payload, MSB first
  always_ff @(posedge clk) begin
    if (state != RX_HUNT) begin
      shreg <= {shreg[37:0], linkrx};
    end
  end

  // Liveness watchdog, refreshed by any received frame
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      wd_cnt  <= '0;
    end else if (rx_done) begin
      running <= 1'b1;
      wd_cnt  <= '0;
    end else if (running) begin
      wd_cnt <= wd_cnt + 1'b1;
      if (wd_cnt == WD_W'(`HL2_RUNNING_TIMEOUT - 1)) begin
        running <= 1'b0;
      end
    end
  end

  // Slave asks for the clock-enable command on link-up
  always_ff @(posedge clk) begin
    if (reset) begin
      clk1on_rqst <= 1'b0;
    end else if (clk1on_ack) begin
      clk1on_rqst <= 1'b0;
    end else if (rx_done && !running && !master_sel) begin
      clk1on_rqst <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- link/link_tx.sv
`default_nettype none

`include "hl2link_cfg.svh"

module link_tx (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           tx_valid,
  input  wire hl2link_pkg::link_frame_t tx_frame,
  output logic                          tx_ready,
  output logic                          tx_done,
  output logic [1:0]                    linktx
);

  import hl2link_pkg::*;

  // Count of the symbol on the line in TX_DATA, 0 is the type symbol
  localparam logic [4:0] LAST_SYM = 5'd19;

  tx_state_t   state;
  logic [4:0]  sym_cnt;
  logic [39:0] shreg;

  assign tx_ready = (state == TX_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= TX_IDLE;
      sym_cnt <= '0;
      tx_done <= 1'b0;
      linktx  <= 2'b00;
    end else begin
      tx_done <= 1'b0;
      case (state)
        TX_IDLE: begin
          if (tx_valid) begin
            linktx <= `HL2_START_SYM;
            state  <= TX_TYPE;
          end
        end
        TX_TYPE: begin
          linktx  <= shreg[39:38];
          sym_cnt <= '0;
          state   <= TX_DATA;
        end
        TX_DATA: begin
          if (sym_cnt == LAST_SYM) begin
            linktx <= 2'b00;
            state  <= TX_IDLE;
          end else begin
            linktx  <= shreg[39:38];
            sym_cnt <= sym_cnt + 5'd1;
            // Done goes out with the last payload symbol
            tx_done <= (sym_cnt == LAST_SYM - 5'd1);
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Frame enters at accept, then shifts out MSB first
  always_ff @(posedge clk) begin
    if (tx_ready && tx_valid) begin
      shreg <= tx_frame;
    end else if (!tx_ready) begin
      shreg <= {shreg[37:0], 2'b00};
    end
  end

endmodule

`default_nettype wire

//--- common/hl2link_pkg.sv
`default_nettype none

package hl2link_pkg;

  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [23:0] sample_t;
  typedef logic [37:0] link_word_t;

  typedef enum logic [1:0] {
    FT_KEEPALIVE = 2'b00,
    FT_CMD       = 2'b01,
    FT_SAMPLE    = 2'b10
  } frame_type_t;

  // Command payload is {addr, data}, sample payload is {sample, zeros}
  typedef struct packed {
    frame_type_t ftype;
    link_word_t  payload;
  } link_frame_t;

  // mask[1] sends to the remote end, mask[0] delivers locally
  typedef struct packed {
    cmd_addr_t  addr;
    cmd_data_t  data;
    logic       resprqst;
    logic       is_alt;
    logic [1:0] mask;
  } host_cmd_t;

  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      resprqst;
    logic      is_alt;
  } local_cmd_t;

  typedef enum logic [2:0] {
    CMD_IDLE,
    CMD_MST0,
    CMD_MST1,
    CMD_SLV0,
    CMD_CLK0,
    CMD_CLK1
  } cmd_state_t;

  typedef enum logic [1:0] {TX_IDLE, TX_TYPE, TX_DATA} tx_state_t;

  typedef enum logic [1:0] {RX_HUNT, RX_TYPE, RX_DATA} rx_state_t;

endpackage

`default_nettype wire

//--- common/hl2link_cfg.svh
`ifndef HL2LINK_CFG_SVH
`define HL2LINK_CFG_SVH

// Control register and its bit fields
`define HL2_CTRL_ADDR        6'h39
`define HL2_MASTER_EN_BIT    11
`define HL2_MASTER_VAL_BIT   8
`define HL2_RESET_EN_BIT     7
`define HL2_RESET_SEL_BIT    4

// Clock-enable command issued by the slave on link-up
`define HL2_CLK1ON_DATA      32'h0000000d

`define HL2_KEEPALIVE_CYCLES 64
`define HL2_RUNNING_TIMEOUT  256

`define HL2_START_SYM        2'b11

`endif
